// File: rtl/cshPkg.sv
package cshPkg;

  localparam int NumWays = 4;
  localparam int CoreWaitLimit = 16;
  localparam int WaitCntWidth = $clog2(CoreWaitLimit + 1);
  localparam int DiagWidth = 8;
  localparam int DiagSelWidth = 3;

  typedef logic [NumWays-1:0] WayVec;
  typedef logic [$clog2(NumWays)-1:0] WayIdx;

  // One-hot requester tag that is zero when no cycle is held
  typedef enum logic [3:0] {
    MbCyc   = 4'b0001,
    ChanCyc = 4'b0010,
    EboxCyc = 4'b0100,
    CcaCyc  = 4'b1000
  } CycleType;

  typedef enum logic [2:0] {
    PhIdle,
    PhT0,
    PhT1,
    PhT2,
    PhT3
  } Phase;

  // Single-cycle outcome strobes of a cache cycle
  typedef struct packed {
    logic mboxResp;
    logic cacheWrite;
    logic coreWrite;
    logic writeback;
    logic eboxRetry;
    logic invalidate;
    logic coreTimeout;
  } Outcome;

endpackage

// File: rtl/wayMatchIf.sv
interface wayMatchIf;

  logic anyValid;
  logic readFound;
  logic anyWrittenMatch;
  logic victimWritten;

  modport source (
    output anyValid,
    output readFound,
    output anyWrittenMatch,
    output victimWritten
  );

  modport sink (
    input anyValid,
    input readFound,
    input anyWrittenMatch,
    input victimWritten
  );

endinterface

// File: rtl/cycleArbiter.sv
module cycleArbiter import cshPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     mbReq,
  input  logic     chanReq,
  input  logic     eboxReq,
  input  logic     ccaReq,
  input  logic     readyToGo,
  output logic     mbGrant,
  output logic     chanGrant,
  output logic     eboxGrant,
  output logic     ccaGrant,
  output logic     anyGrant,
  output CycleType cycleType
);

  CycleType grantTag;

  // Memory buffer has top priority, then channel, EBOX and cache clear
  assign mbGrant = readyToGo & mbReq;
  assign chanGrant = readyToGo & ~mbReq & chanReq;
  assign eboxGrant = readyToGo & ~mbReq & ~chanReq & eboxReq;
  assign ccaGrant = readyToGo & ~mbReq & ~chanReq & ~eboxReq & ccaReq;
  assign anyGrant = mbGrant | chanGrant | eboxGrant | ccaGrant;

  always_comb begin
    grantTag = CycleType'('0);
    if (mbGrant) begin
      grantTag = MbCyc;
    end else if (chanGrant) begin
      grantTag = ChanCyc;
    end else if (eboxGrant) begin
      grantTag = EboxCyc;
    end else if (ccaGrant) begin
      grantTag = CcaCyc;
    end
  end

  // Cycle type holds while the cache is busy
  always_ff @(posedge clk) begin
    if (reset) begin
      cycleType <= CycleType'('0);
    end else if (anyGrant) begin
      cycleType <= grantTag;
    end else if (readyToGo) begin
      cycleType <= CycleType'('0);
    end
  end

  grantOneHot: assert property (
    @(posedge clk) disable iff (reset)
    $onehot0({mbGrant, chanGrant, eboxGrant, ccaGrant})
  ) else $error("more than one grant strobe");

  typeHeldWhileBusy: assert property (
    @(posedge clk) disable iff (reset)
    !readyToGo |=> $stable(cycleType)
  ) else $error("cycle type changed while cache busy");

endmodule

// File: rtl/cycleTimer.sv
module cycleTimer import cshPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic start,
  input  logic waitEnable,
  output Phase phase,
  output logic waitExpired
);

  logic [WaitCntWidth-1:0] waitCount;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= PhIdle;
    end else begin
      case (phase)
        PhIdle:  phase <= start ? PhT0 : PhIdle;
        PhT0:    phase <= PhT1;
        PhT1:    phase <= PhT2;
        PhT2:    phase <= PhT3;
        default: phase <= PhIdle;
      endcase
    end
  end

  // Core wait count that stops at the limit
  always_ff @(posedge clk) begin
    if (reset || !waitEnable) begin
      waitCount <= '0;
    end else if (!waitExpired) begin
      waitCount <= waitCount + 1'b1;
    end
  end

  assign waitExpired = waitCount == WaitCntWidth'(CoreWaitLimit);

  startWhenIdle: assert property (
    @(posedge clk) disable iff (reset)
    start |-> phase == PhIdle
  ) else $error("cycle start while phase chain running");

endmodule

// File: rtl/wayMatch.sv
module wayMatch import cshPkg::*; (
  input  WayVec     validMatch,
  input  WayVec     wordValid,
  input  WayVec     wayWritten,
  input  WayIdx     lruWay,
  wayMatchIf.source summary
);

  assign summary.anyValid = |validMatch;

  // A hit needs the addressed word to be valid as well
  assign summary.readFound = |(validMatch & wordValid);

  assign summary.anyWrittenMatch = |(validMatch & wayWritten);

  // Victim is the least recently used way
  assign summary.victimWritten = wayWritten[lruWay];

endmodule

// File: rtl/cacheSequencer.sv
module cacheSequencer import cshPkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          anyGrant,
  input  CycleType      cycleType,
  input  Phase          phase,
  wayMatchIf.sink       summary,
  input  logic          eboxWrite,
  input  logic          coreDataValid,
  input  logic          waitExpired,
  output logic          readyToGo,
  output logic          waitEnable,
  output logic          mboxResp,
  output logic          cacheWrite,
  output logic          coreWrite,
  output logic          coreReadReq,
  output logic          writeback,
  output logic          eboxRetry,
  output logic          invalidate,
  output logic          coreTimeout
);

  typedef enum logic [1:0] {
    Idle,
    Busy,
    CoreWait,
    Fill
  } SeqState;

  SeqState state;
  SeqState stateNext;
  Outcome  outNext;
  Outcome  outQ;
  logic    fillNow;

  always_comb begin
    stateNext = state;
    outNext = '0;
    case (state)
      Idle, Fill: begin
        stateNext = anyGrant ? Busy : Idle;
      end
      Busy: begin
        if (phase == PhT3) begin
          stateNext = Idle;
          if (cycleType == EboxCyc) begin
            if (!eboxWrite) begin
              if (summary.readFound) begin
                outNext.mboxResp = 1'b1;
              end else if (summary.victimWritten) begin
                outNext.writeback = 1'b1;
                outNext.eboxRetry = 1'b1;
              end else begin
                stateNext = CoreWait;
              end
            end else begin
              if (summary.anyValid) begin
                outNext.cacheWrite = 1'b1;
              end else if (summary.victimWritten) begin
                outNext.writeback = 1'b1;
                outNext.eboxRetry = 1'b1;
              end else begin
                outNext.coreWrite = 1'b1;
              end
            end
          end else if (cycleType == CcaCyc && summary.anyValid) begin
            // Dirty line goes back to core, clean line is just dropped
            if (summary.anyWrittenMatch) begin
              outNext.writeback = 1'b1;
            end else begin
              outNext.invalidate = 1'b1;
            end
          end
        end
      end
      CoreWait: begin
        if (coreDataValid) begin
          stateNext = Fill;
        end else if (waitExpired) begin
          stateNext = Idle;
          outNext.coreTimeout = 1'b1;
        end
      end
      default: begin
        stateNext = Idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= Idle;
      outQ <= '0;
    end else begin
      state <= stateNext;
      outQ <= outNext;
    end
  end

  // Fill cycle is also the first ready cycle
  assign fillNow = state == Fill;
  assign readyToGo = (state == Idle) | fillNow;
  assign coreReadReq = state == CoreWait;
  assign waitEnable = state == CoreWait;

  assign mboxResp = outQ.mboxResp | fillNow;
  assign cacheWrite = outQ.cacheWrite | fillNow;
  assign coreWrite = outQ.coreWrite;
  assign writeback = outQ.writeback;
  assign eboxRetry = outQ.eboxRetry;
  assign invalidate = outQ.invalidate;
  assign coreTimeout = outQ.coreTimeout;

  oneWritePath: assert property (
    @(posedge clk) disable iff (reset)
    !(cacheWrite && coreWrite)
  ) else $error("cache write and core write together");

endmodule

// File: rtl/diagReadout.sv
module diagReadout import cshPkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    diagRead,
  input  logic [DiagSelWidth-1:0] diagSel,
  input  logic                    readyToGo,
  input  CycleType                cycleType,
  input  Phase                    phase,
  input  logic                    coreReadReq,
  output logic [DiagWidth-1:0]    diagData
);

  logic [DiagWidth-1:0] statusByte;

  always_comb begin
    case (diagSel)
      3'd0:    statusByte = DiagWidth'({coreReadReq, readyToGo});
      3'd1:    statusByte = DiagWidth'(cycleType);
      3'd2:    statusByte = DiagWidth'(phase);
      default: statusByte = '0;
    endcase
  end

  // Bus reads zero when not selected
  always_ff @(posedge clk) begin
    if (reset) begin
      diagData <= '0;
    end else begin
      diagData <= diagRead ? statusByte : '0;
    end
  end

endmodule

// File: rtl/cacheControl.sv
module cacheControl import cshPkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    mbReq,
  input  logic                    chanReq,
  input  logic                    eboxReq,
  input  logic                    ccaReq,
  input  logic                    eboxWrite,
  input  WayVec                   validMatch,
  input  WayVec                   wordValid,
  input  WayVec                   wayWritten,
  input  WayIdx                   lruWay,
  input  logic                    coreDataValid,
  input  logic                    diagRead,
  input  logic [DiagSelWidth-1:0] diagSel,
  output logic                    readyToGo,
  output logic                    mbGrant,
  output logic                    chanGrant,
  output logic                    eboxGrant,
  output logic                    ccaGrant,
  output CycleType                cycleType,
  output logic                    mboxResp,
  output logic                    cacheWrite,
  output logic                    coreWrite,
  output logic                    coreReadReq,
  output logic                    writeback,
  output logic                    eboxRetry,
  output logic                    invalidate,
  output logic                    coreTimeout,
  output logic [DiagWidth-1:0]    diagData
);

  logic anyGrant;
  Phase phase;
  logic waitEnable;
  logic waitExpired;

  wayMatchIf summary();

  cycleArbiter u_cycleArbiter (
    .clk       (clk),
    .reset     (reset),
    .mbReq     (mbReq),
    .chanReq   (chanReq),
    .eboxReq   (eboxReq),
    .ccaReq    (ccaReq),
    .readyToGo (readyToGo),
    .mbGrant   (mbGrant),
    .chanGrant (chanGrant),
    .eboxGrant (eboxGrant),
    .ccaGrant  (ccaGrant),
    .anyGrant  (anyGrant),
    .cycleType (cycleType)
  );

  // Every grant kicks off the phase chain
  cycleTimer u_cycleTimer (
    .clk         (clk),
    .reset       (reset),
    .start       (anyGrant),
    .waitEnable  (waitEnable),
    .phase       (phase),
    .waitExpired (waitExpired)
  );

  wayMatch u_wayMatch (
    .validMatch (validMatch),
    .wordValid  (wordValid),
    .wayWritten (wayWritten),
    .lruWay     (lruWay),
    .summary    (summary.source)
  );

  cacheSequencer u_cacheSequencer (
    .clk           (clk),
    .reset         (reset),
    .anyGrant      (anyGrant),
    .cycleType     (cycleType),
    .phase         (phase),
    .summary       (summary.sink),
    .eboxWrite     (eboxWrite),
    .coreDataValid (coreDataValid),
    .waitExpired   (waitExpired),
    .readyToGo     (readyToGo),
    .waitEnable    (waitEnable),
    .mboxResp      (mboxResp),
    .cacheWrite    (cacheWrite),
    .coreWrite     (coreWrite),
    .coreReadReq   (coreReadReq),
    .writeback     (writeback),
    .eboxRetry     (eboxRetry),
    .invalidate    (invalidate),
    .coreTimeout   (coreTimeout)
  );

  diagReadout u_diagReadout (
    .clk         (clk),
    .reset       (reset),
    .diagRead    (diagRead),
    .diagSel     (diagSel),
    .readyToGo   (readyToGo),
    .cycleType   (cycleType),
    .phase       (phase),
    .coreReadReq (coreReadReq),
    .diagData    (diagData)
  );

endmodule

// File: verif/cacheControlTb.sv
module cacheControlTb import cshPkg::*; ();

  localparam int ClkPeriod = 100;
  localparam int NumTrans = 800;
  localparam int WatchdogCycles = (NumTrans + 2) * (CoreWaitLimit + 8);

  logic clk;
  logic reset;
  logic mbReq;
  logic chanReq;
  logic eboxReq;
  logic ccaReq;
  logic eboxWrite;
  WayVec validMatch;
  WayVec wordValid;
  WayVec wayWritten;
  WayIdx lruWay;
  logic coreDataValid;
  logic diagRead;
  logic [DiagSelWidth-1:0] diagSel;
  logic readyToGo;
  logic mbGrant;
  logic chanGrant;
  logic eboxGrant;
  logic ccaGrant;
  CycleType cycleType;
  logic mboxResp;
  logic cacheWrite;
  logic coreWrite;
  logic coreReadReq;
  logic writeback;
  logic eboxRetry;
  logic invalidate;
  logic coreTimeout;
  logic [DiagWidth-1:0] diagData;

  // Reference model state with mPhase 0 when idle and 1 to 4 for T0 to T3
  logic [3:0] mType;
  logic [2:0] mPhase;
  logic mWaiting;
  int mWaitCnt;
  logic [DiagWidth-1:0] mDiag;
  logic expMboxResp;
  logic expCacheWrite;
  logic expCoreWrite;
  logic expWriteback;
  logic expEboxRetry;
  logic expInvalidate;
  logic expCoreTimeout;

  integer seed;
  int transCount;
  int hitCount;
  int retryCount;
  int coreWriteCount;
  int fillCount;
  int timeoutCount;
  int ccaWbCount;
  int invalCount;

  cacheControl u_cacheControl (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired before all cache cycles completed");
    stopWithFailure();
  end

  task automatic stopWithFailure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      stopWithFailure();
    end
  endtask

  function automatic logic modelReady();
    return (mPhase == 3'd0) && !mWaiting;
  endfunction

  // Grant bits in the same order as the cycle-type tag
  function automatic logic [3:0] expectedGrants();
    if (!modelReady()) return 4'b0000;
    if (mbReq) return 4'b0001;
    if (chanReq) return 4'b0010;
    if (eboxReq) return 4'b0100;
    if (ccaReq) return 4'b1000;
    return 4'b0000;
  endfunction

  task automatic driveInputs();
    logic allowReq;
    allowReq = transCount < NumTrans;
    mbReq = allowReq && ($random(seed) % 8 == 0);
    chanReq = allowReq && ($random(seed) % 8 == 0);
    eboxReq = allowReq && ($random(seed) % 2 == 0);
    ccaReq = allowReq && ($random(seed) % 3 == 0);
    eboxWrite = $random(seed) % 2 == 0;
    // Sparse matches so that misses are common
    validMatch = WayVec'($random(seed) & $random(seed));
    wordValid = WayVec'($random(seed));
    wayWritten = WayVec'($random(seed));
    lruWay = WayIdx'($random(seed));
    coreDataValid = $random(seed) % 10 == 0;
    diagRead = $random(seed) % 2 == 0;
    diagSel = DiagSelWidth'($random(seed));
  endtask

  task automatic checkOutputs();
    checkValue("readyToGo", 32'(modelReady()), 32'(readyToGo));
    checkValue("grants", 32'(expectedGrants()),
               32'({ccaGrant, eboxGrant, chanGrant, mbGrant}));
    checkValue("cycleType", 32'(mType), 32'(cycleType));
    checkValue("mboxResp", 32'(expMboxResp), 32'(mboxResp));
    checkValue("cacheWrite", 32'(expCacheWrite), 32'(cacheWrite));
    checkValue("coreWrite", 32'(expCoreWrite), 32'(coreWrite));
    checkValue("coreReadReq", 32'(mWaiting), 32'(coreReadReq));
    checkValue("writeback", 32'(expWriteback), 32'(writeback));
    checkValue("eboxRetry", 32'(expEboxRetry), 32'(eboxRetry));
    checkValue("invalidate", 32'(expInvalidate), 32'(invalidate));
    checkValue("coreTimeout", 32'(expCoreTimeout), 32'(coreTimeout));
    checkValue("diagData", 32'(mDiag), 32'(diagData));
  endtask

  task automatic advanceModel();
    logic ready;
    logic [3:0] grants;
    logic anyValid;
    logic readFound;
    logic writtenMatch;
    logic victimDirty;
    logic [DiagWidth-1:0] status;
    ready = modelReady();
    grants = expectedGrants();
    anyValid = validMatch != '0;
    readFound = (validMatch & wordValid) != '0;
    writtenMatch = (validMatch & wayWritten) != '0;
    victimDirty = wayWritten[lruWay];
    case (diagSel)
      3'd0:    status = {6'b0, mWaiting, ready};
      3'd1:    status = {4'b0, mType};
      3'd2:    status = {5'b0, mPhase};
      default: status = '0;
    endcase
    mDiag = diagRead ? status : '0;
    {expMboxResp, expCacheWrite, expCoreWrite, expWriteback} = 4'b0000;
    {expEboxRetry, expInvalidate, expCoreTimeout} = 3'b000;
    if (mWaiting) begin
      if (coreDataValid) begin
        mWaiting = 1'b0;
        expMboxResp = 1'b1;
        expCacheWrite = 1'b1;
        fillCount++;
      end else if (mWaitCnt == CoreWaitLimit) begin
        mWaiting = 1'b0;
        expCoreTimeout = 1'b1;
        timeoutCount++;
      end else begin
        mWaitCnt++;
      end
    end
    if (mPhase == 3'd4) begin
      mPhase = 3'd0;
      if (mType == 4'b0100 && !eboxWrite) begin
        if (readFound) begin
          expMboxResp = 1'b1;
          hitCount++;
        end else if (victimDirty) begin
          expWriteback = 1'b1;
          expEboxRetry = 1'b1;
          retryCount++;
        end else begin
          mWaiting = 1'b1;
          mWaitCnt = 0;
        end
      end else if (mType == 4'b0100) begin
        if (anyValid) begin
          expCacheWrite = 1'b1;
          hitCount++;
        end else if (victimDirty) begin
          expWriteback = 1'b1;
          expEboxRetry = 1'b1;
          retryCount++;
        end else begin
          expCoreWrite = 1'b1;
          coreWriteCount++;
        end
      end else if (mType == 4'b1000 && anyValid) begin
        expWriteback = writtenMatch;
        expInvalidate = !writtenMatch;
        if (writtenMatch) ccaWbCount++;
        else invalCount++;
      end
    end else if (mPhase != 3'd0) begin
      mPhase = mPhase + 3'd1;
    end else if (grants != 4'b0000) begin
      mPhase = 3'd1;
    end
    // Tag holds through the cycle and clears once ready with no new grant
    if (grants != 4'b0000) begin
      mType = grants;
      transCount++;
    end else if (ready) begin
      mType = 4'b0000;
    end
  endtask

  task automatic runCycle();
    driveInputs();
    #(ClkPeriod / 4);
    checkOutputs();
    advanceModel();
    @(negedge clk);
  endtask

  initial begin
    seed = 32'h247b;
    reset = 1'b1;
    {mbReq, chanReq, eboxReq, ccaReq, eboxWrite} = 5'b00000;
    validMatch = '0;
    wordValid = '0;
    wayWritten = '0;
    lruWay = '0;
    coreDataValid = 1'b0;
    diagRead = 1'b0;
    diagSel = '0;
    mType = '0;
    mPhase = '0;
    mWaiting = 1'b0;
    mWaitCnt = 0;
    mDiag = '0;
    {expMboxResp, expCacheWrite, expCoreWrite, expWriteback} = 4'b0000;
    {expEboxRetry, expInvalidate, expCoreTimeout} = 3'b000;
    {transCount, hitCount, retryCount, coreWriteCount} = '0;
    {fillCount, timeoutCount, ccaWbCount, invalCount} = '0;
    repeat (2) @(negedge clk);
    reset = 1'b0;
    while (transCount < NumTrans || mPhase != 3'd0 || mWaiting) begin
      runCycle();
    end
    // Let the last outcome pulse show
    repeat (2) runCycle();
    $display("Cycles %0d: hit %0d retry %0d coreWrite %0d fill %0d timeout %0d",
             transCount, hitCount, retryCount, coreWriteCount, fillCount, timeoutCount);
    $display("CCA writeback %0d invalidate %0d", ccaWbCount, invalCount);
    if (hitCount > 0 && retryCount > 0 && coreWriteCount > 0 && fillCount > 0 &&
        timeoutCount > 0 && ccaWbCount > 0 && invalCount > 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Random stimulus did not reach every cycle outcome");
      stopWithFailure();
    end
  end

endmodule

// File: cacheControl.f
rtl/cshPkg.sv
rtl/wayMatchIf.sv
rtl/cycleArbiter.sv
rtl/cycleTimer.sv
rtl/wayMatch.sv
rtl/cacheSequencer.sv
rtl/diagReadout.sv
rtl/cacheControl.sv
verif/cacheControlTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= cacheControlTb
LINT_TOP ?= cacheControl
FILELIST ?= cacheControl.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJDIR)
